/* verilog.f */
+incdir+.
slink_mux_pkg.sv
port_slice.sv
rr_arbiter.sv
rsp_router.sv
slink_mux_top.sv
slink_mux_checker.sv
tb_slink_monitor.sv
tb_slink_mux.sv

/* run.sh */
#!/bin/sh
# Build the multiplexer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_slink_mux \
  -f verilog.f -o sim_slink_mux
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_slink_mux)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

/* slink_mux_stim.txt */
# R port id addr data | S port id resp | W stall_cycles | K port expected_ready
# B id addr data order0 order1 order2 order3 (expected master port order)
R 0 3 00001000 a0000001
R 2 5 00000000 a0000002
R 3 f 00002000 a0000003
S 0 3 1
S 2 5 0
S 3 f 2
B 7 00003000 b0000000 0 1 2 3
R 1 2 00004000 c0000001
B 9 00005000 d0000000 2 3 0 1
R 1 4 00000000 c0000002
R 1 5 00006000 c0000003
R 1 6 00006010 c0000004
R 1 7 00000000 c0000005
R 1 8 00006020 c0000006
K 1 0
S 1 7 3
K 1 1
W 8
R 0 a 00007000 e0000001
R 0 b 00007010 e0000002
R 0 c 00007020 e0000003

/* tb_slink_mux.sv */
// Testbench top for the write-request multiplexer: clock, reset, stimulus file and DUT drive
`default_nettype none

`include "mux_settings.svh"

module tb_slink_mux;

  localparam int Timeout = 60;   // Cycles per wait

  logic                                          periph_clk    = 1'b0;
  logic                                          rst_n         = 1'b0;
  logic [`MUX_NUM_PORTS-1:0]                     port_valid    = '0;
  slink_mux_pkg::port_req_t [`MUX_NUM_PORTS-1:0] port_req      = '0;
  logic [`MUX_NUM_PORTS-1:0]                     port_ready;
  logic [`MUX_NUM_PORTS-1:0]                     rsp_valid;
  slink_mux_pkg::port_rsp_t                      rsp;
  logic                                          mst_valid;
  slink_mux_pkg::mst_req_t                       mst_req;
  logic                                          mst_ready     = 1'b1;
  logic                                          mst_rsp_valid = 1'b0;
  slink_mux_pkg::mst_rsp_t                       mst_rsp       = '0;
  logic                                          exp_push      = 1'b0;
  slink_mux_pkg::port_idx_t                      exp_port      = '0;
  logic                                          rdy_chk       = 1'b0;
  logic                                          rdy_exp       = 1'b0;
  int                                            errors;
  int                                            pending;
  int                                            other_errs    = 0;
  int                                            cycle         = 0;
  int                                            stall_end     = 0;
  logic [15:0]                                   lfsr          = 16'd5734;

  always #10 periph_clk = ~periph_clk;

  // Master ready drops until the stall cycle is reached
  always @(posedge periph_clk) begin
    #2;
    cycle     = cycle + 1;
    mst_ready = (cycle >= stall_end);
  end

  slink_mux_top slink_mux_top_inst (
    .periph_clk       ( periph_clk    ),
    .rst_n_i          ( rst_n         ),
    .port_req_valid_i ( port_valid    ),
    .port_req_i       ( port_req      ),
    .port_req_ready_o ( port_ready    ),
    .port_rsp_valid_o ( rsp_valid     ),
    .port_rsp_o       ( rsp           ),
    .mst_valid_o      ( mst_valid     ),
    .mst_req_o        ( mst_req       ),
    .mst_ready_i      ( mst_ready     ),
    .mst_rsp_valid_i  ( mst_rsp_valid ),
    .mst_rsp_i        ( mst_rsp       )
  );

  tb_slink_monitor monitor_inst (
    .periph_clk       ( periph_clk    ),
    .rst_n_i          ( rst_n         ),
    .port_req_valid_i ( port_valid    ),
    .port_req_i       ( port_req      ),
    .port_req_ready_i ( port_ready    ),
    .port_rsp_valid_i ( rsp_valid     ),
    .port_rsp_i       ( rsp           ),
    .mst_valid_i      ( mst_valid     ),
    .mst_req_i        ( mst_req       ),
    .mst_ready_i      ( mst_ready     ),
    .mst_rsp_valid_i  ( mst_rsp_valid ),
    .mst_rsp_i        ( mst_rsp       ),
    .exp_push_i       ( exp_push      ),
    .exp_port_i       ( exp_port      ),
    .rdy_chk_i        ( rdy_chk       ),
    .rdy_exp_i        ( rdy_exp       ),
    .errors_o         ( errors        ),
    .pending_o        ( pending       )
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_addr(output slink_mux_pkg::addr_t a);
    for (int i = 0; i < `MUX_ADDR_W; i++) begin
      lfsr = lfsr_step(lfsr);
      a[i] = lfsr[0];
    end
  endtask

  // One-cycle note to the monitor, either a master order or a ready check
  task automatic note_expect(input int p, input logic is_order, input logic rdy_v);
    exp_port = slink_mux_pkg::port_idx_t'(p);
    exp_push = is_order;
    rdy_chk  = ~is_order;
    rdy_exp  = rdy_v;
    @(posedge periph_clk);
    #1;
    exp_push = 1'b0;
    rdy_chk  = 1'b0;
  endtask

  task automatic send_reqs(input logic [`MUX_NUM_PORTS-1:0] mask);
    logic [`MUX_NUM_PORTS-1:0] taken;
    int                        t;
    t          = 0;
    port_valid = mask;
    while (port_valid != '0 && t < Timeout) begin
      @(negedge periph_clk);
      taken = port_valid & port_ready;
      @(posedge periph_clk);
      #1;
      port_valid = port_valid & ~taken;
      t++;
    end
    if (port_valid != '0) begin
      $display("Timeout: port requests %b were never accepted", port_valid);
      other_errs++;
      port_valid = '0;
    end
  endtask

  task automatic send_rsp(input int p, input slink_mux_pkg::port_id_t id,
                          input slink_mux_pkg::resp_t r);
    mst_rsp.id    = {slink_mux_pkg::port_idx_t'(p), id};
    mst_rsp.resp  = r;
    mst_rsp_valid = 1'b1;
    @(posedge periph_clk);
    #1;
    mst_rsp_valid = 1'b0;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int                       fd;
    int                       code;
    int                       p;
    int                       n;
    int                       t;
    int                       asrt_errs;
    int                       ord[`MUX_NUM_PORTS];
    string                    tok;
    logic [8*160-1:0]         skip_buf;
    slink_mux_pkg::port_id_t  id;
    slink_mux_pkg::addr_t     a;
    slink_mux_pkg::data_t     d;
    slink_mux_pkg::resp_t     r;
    repeat (16) @(posedge periph_clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen("slink_mux_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      other_errs++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          code = $fgets(skip_buf, fd);
        end else if (tok == "R") begin
          code = $fscanf(fd, "%d %h %h %h", p, id, a, d);
          if (a == '0) draw_addr(a);   // Zero means random
          note_expect(p, 1'b1, 1'b0);
          port_req[p] = '{addr: a, data: d, id: id};
          send_reqs(`MUX_NUM_PORTS'(1) << p);
        end else if (tok == "B") begin
          code = $fscanf(fd, "%h %h %h %d %d %d %d", id, a, d, ord[0], ord[1], ord[2], ord[3]);
          for (int i = 0; i < `MUX_NUM_PORTS; i++) note_expect(ord[i], 1'b1, 1'b0);
          for (int i = 0; i < `MUX_NUM_PORTS; i++) begin
            port_req[i] = '{addr: a + (i << 4), data: d + i, id: id};
          end
          send_reqs('1);
        end else if (tok == "S") begin
          code = $fscanf(fd, "%d %h %h", p, id, r);
          send_rsp(p, id, r);
        end else if (tok == "W") begin
          code = $fscanf(fd, "%d", n);
          stall_end = cycle + n + 1;   // Ready low for the next n edges
        end else if (tok == "K") begin
          code = $fscanf(fd, "%d %d", p, n);
          note_expect(p, 1'b0, n[0]);
        end else begin
          $display("Unknown stimulus operation %s", tok);
          other_errs++;
        end
      end
      $fclose(fd);
    end
    // Let every accepted request reach the master
    t = 0;
    while (pending != 0 && t < 4 * Timeout) begin
      @(posedge periph_clk);
      t++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d expected master transfers never arrived", pending);
      other_errs++;
    end
    repeat (4) @(posedge periph_clk);
    asrt_errs = slink_mux_top_inst.slink_mux_checker_inst.fail_cnt;
    $display("Closing: %0d value errors, %0d assertion failures, %0d other failures",
             errors, asrt_errs, other_errs);
    if (errors == 0 && asrt_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_slink_monitor.sv */
// Testbench monitor: builds expected master requests and responses, compares and counts errors
`default_nettype none

`include "mux_settings.svh"

module tb_slink_monitor (
  input  wire logic                                          periph_clk,
  input  wire logic                                          rst_n_i,
  input  wire logic [`MUX_NUM_PORTS-1:0]                     port_req_valid_i,
  input  wire slink_mux_pkg::port_req_t [`MUX_NUM_PORTS-1:0] port_req_i,
  input  wire logic [`MUX_NUM_PORTS-1:0]                     port_req_ready_i,
  input  wire logic [`MUX_NUM_PORTS-1:0]                     port_rsp_valid_i,
  input  wire slink_mux_pkg::port_rsp_t                      port_rsp_i,
  input  wire logic                                          mst_valid_i,
  input  wire slink_mux_pkg::mst_req_t                       mst_req_i,
  input  wire logic                                          mst_ready_i,
  input  wire logic                                          mst_rsp_valid_i,
  input  wire slink_mux_pkg::mst_rsp_t                       mst_rsp_i,
  input  wire logic                                          exp_push_i,  // Next master port
  input  wire slink_mux_pkg::port_idx_t                      exp_port_i,
  input  wire logic                                          rdy_chk_i,
  input  wire logic                                          rdy_exp_i,
  output int                                                 errors_o,
  output int                                                 pending_o
);

  slink_mux_pkg::mst_req_t  exp_q[$];    // Accepted, not yet seen at the master
  slink_mux_pkg::port_idx_t order_q[$];
  int                       err_cnt = 0;
  int                       pend    = 0;

  assign errors_o  = err_cnt;
  assign pending_o = pend;

  task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
    if (exp_v !== got_v) begin
      $display("Fail %s exp %h got %h", name, exp_v, got_v);
      err_cnt++;
    end
  endtask

  // Everything is settled half a cycle after the drive
  always @(negedge periph_clk) begin
    slink_mux_pkg::mst_req_t  exp_req;
    slink_mux_pkg::port_idx_t src;
    int                       hit;
    if (!rst_n_i) begin
      compare("mst_valid_o", 32'd0, 32'(mst_valid_i));
      compare("port_rsp_valid_o", 32'd0, 32'(port_rsp_valid_i));
    end else begin
      if (exp_push_i) order_q.push_back(exp_port_i);
      if (rdy_chk_i) begin
        compare("port_req_ready_o", 32'(rdy_exp_i), 32'(port_req_ready_i[exp_port_i]));
      end
      for (int p = 0; p < `MUX_NUM_PORTS; p++) begin
        if (port_req_valid_i[p] && port_req_ready_i[p]) begin
          exp_req.addr = port_req_i[p].addr;
          exp_req.data = port_req_i[p].data;
          exp_req.id   = {slink_mux_pkg::port_idx_t'(p), port_req_i[p].id};  // Origin in front
          exp_q.push_back(exp_req);
        end
      end
      if (mst_valid_i && mst_ready_i) begin
        if (order_q.size() == 0) begin
          $display("Master transfer arrived with no expected port order");
          err_cnt++;
        end else begin
          src = order_q.pop_front();
          compare("mst_req_o.id port", 32'(src), 32'(mst_req_i.id[`MUX_ID_W +: `MUX_PORT_IDX_W]));
          hit = -1;
          for (int i = exp_q.size() - 1; i >= 0; i--) begin
            exp_req = exp_q[i];
            if (exp_req.id[`MUX_ID_W +: `MUX_PORT_IDX_W] == src) hit = i;
          end
          if (hit < 0) begin
            $display("Master transfer for port %0d had no accepted request", src);
            err_cnt++;
          end else begin
            exp_req = exp_q[hit];
            compare("mst_req_o.id", 32'(exp_req.id), 32'(mst_req_i.id));
            compare("mst_req_o.addr", exp_req.addr, mst_req_i.addr);
            compare("mst_req_o.data", exp_req.data, mst_req_i.data);
            exp_q.delete(hit);
          end
        end
      end
      // Response goes to the prefix port only, prefix stripped
      if (mst_rsp_valid_i) begin
        compare("port_rsp_valid_o",
                32'(`MUX_NUM_PORTS'(1) << mst_rsp_i.id[`MUX_ID_W +: `MUX_PORT_IDX_W]),
                32'(port_rsp_valid_i));
        compare("port_rsp_o.id", 32'(mst_rsp_i.id[`MUX_ID_W-1:0]), 32'(port_rsp_i.id));
        compare("port_rsp_o.resp", 32'(mst_rsp_i.resp), 32'(port_rsp_i.resp));
      end else begin
        compare("port_rsp_valid_o", 32'd0, 32'(port_rsp_valid_i));
      end
    end
    pend = exp_q.size() + order_q.size();
  end

endmodule

`default_nettype wire

/* slink_mux_checker.sv */
// Protocol checker for the write-request multiplexer, bound into its top level
`default_nettype none

`include "mux_settings.svh"

module slink_mux_checker (
  input wire logic                          periph_clk,
  input wire logic                          rst_n_i,
  input wire logic [`MUX_NUM_PORTS-1:0]     port_req_valid_i,
  input wire logic [`MUX_NUM_PORTS-1:0]     port_req_ready_i,
  input wire logic [`MUX_NUM_PORTS-1:0]     port_rsp_valid_i,
  input wire logic                          mst_valid_i,
  input wire slink_mux_pkg::mst_req_t       mst_req_i,
  input wire logic                          mst_ready_i
);

  int fail_cnt = 0;   // Failed assertions so far

  // Held master request must not move
  mst_hold: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    (mst_valid_i && !mst_ready_i) |=> (mst_valid_i && $stable(mst_req_i)))
    else begin
      $error("Master request changed while waiting on ready");
      fail_cnt++;
    end

  rsp_onehot: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    $onehot0(port_rsp_valid_i))
    else begin
      $error("More than one port response valid at once");
      fail_cnt++;
    end

  for (genvar p = 0; p < `MUX_NUM_PORTS; p++) begin : gen_port
    logic [`MUX_CNT_W-1:0] cnt_q;   // Outstanding, seen from the pins

    always_ff @(posedge periph_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + `MUX_CNT_W'(port_req_valid_i[p] & port_req_ready_i[p])
                       - `MUX_CNT_W'(port_rsp_valid_i[p]);
      end
    end

    at_limit: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      (cnt_q >= `MUX_CNT_W'(`MUX_MAX_OUTSTANDING)) |-> !port_req_ready_i[p])
      else begin
        $error("Port %0d ready while at the outstanding limit", p);
        fail_cnt++;
      end
  end

endmodule

bind slink_mux_top slink_mux_checker slink_mux_checker_inst (
  .periph_clk       ( periph_clk       ),
  .rst_n_i          ( rst_n_i          ),
  .port_req_valid_i ( port_req_valid_i ),
  .port_req_ready_i ( port_req_ready_o ),
  .port_rsp_valid_i ( port_rsp_valid_o ),
  .mst_valid_i      ( mst_valid_o      ),
  .mst_req_i        ( mst_req_o        ),
  .mst_ready_i      ( mst_ready_i      )
);

`default_nettype wire

/* slink_mux_top.sv */
// Write-request multiplexer top: port slices, round-robin arbiter and response router
`default_nettype none

`include "mux_settings.svh"

module slink_mux_top (
  input  wire logic                                          periph_clk,
  input  wire logic                                          rst_n_i,
  // Requester ports
  input  wire logic [`MUX_NUM_PORTS-1:0]                     port_req_valid_i,
  input  wire slink_mux_pkg::port_req_t [`MUX_NUM_PORTS-1:0] port_req_i,
  output logic [`MUX_NUM_PORTS-1:0]                          port_req_ready_o,
  output logic [`MUX_NUM_PORTS-1:0]                          port_rsp_valid_o,
  output slink_mux_pkg::port_rsp_t                           port_rsp_o,
  // Master port
  output logic                                               mst_valid_o,
  output slink_mux_pkg::mst_req_t                            mst_req_o,
  input  wire logic                                          mst_ready_i,
  input  wire logic                                          mst_rsp_valid_i,
  input  wire slink_mux_pkg::mst_rsp_t                       mst_rsp_i
);

  logic [`MUX_NUM_PORTS-1:0]                    slv_valid;
  slink_mux_pkg::mst_req_t [`MUX_NUM_PORTS-1:0] slv_req;
  logic [`MUX_NUM_PORTS-1:0]                    grant;
  logic [`MUX_NUM_PORTS-1:0]                    done;

  ////////////////////
  // Port slices
  ////////////////////

  for (genvar p = 0; p < `MUX_NUM_PORTS; p++) begin : gen_slice
    port_slice port_slice_inst (
      .periph_clk  ( periph_clk                          ),
      .rst_n_i     ( rst_n_i                             ),
      .port_idx_i  ( slink_mux_pkg::port_idx_t'(p)       ),
      .req_valid_i ( port_req_valid_i[p]                 ),
      .req_i       ( port_req_i[p]                       ),
      .req_ready_o ( port_req_ready_o[p]                 ),
      .slv_valid_o ( slv_valid[p]                        ),
      .slv_req_o   ( slv_req[p]                          ),
      .grant_i     ( grant[p]                            ),
      .done_i      ( done[p]                             )
    );
  end

  // Merge onto the master
  rr_arbiter rr_arbiter_inst (
    .periph_clk  ( periph_clk  ),
    .rst_n_i     ( rst_n_i     ),
    .slv_valid_i ( slv_valid   ),
    .slv_req_i   ( slv_req     ),
    .grant_o     ( grant       ),
    .mst_valid_o ( mst_valid_o ),
    .mst_req_o   ( mst_req_o   ),
    .mst_ready_i ( mst_ready_i )
  );

  rsp_router rsp_router_inst (
    .mst_rsp_valid_i  ( mst_rsp_valid_i  ),
    .mst_rsp_i        ( mst_rsp_i        ),
    .port_rsp_valid_o ( port_rsp_valid_o ),
    .port_rsp_o       ( port_rsp_o       ),
    .done_o           ( done             )   // Back to the slice counters
  );

endmodule

`default_nettype wire

/* rsp_router.sv */
// Response steering: decodes the ID prefix, strips it and flags completions per port
`default_nettype none

`include "mux_settings.svh"

module rsp_router (
  input  wire logic                     mst_rsp_valid_i,
  input  wire slink_mux_pkg::mst_rsp_t  mst_rsp_i,
  output logic [`MUX_NUM_PORTS-1:0]     port_rsp_valid_o,
  output slink_mux_pkg::port_rsp_t      port_rsp_o,   // Shared by all ports
  output logic [`MUX_NUM_PORTS-1:0]     done_o
);

  slink_mux_pkg::port_idx_t dst_idx;
  logic [`MUX_NUM_PORTS-1:0] dst_onehot;

  // Origin port sits above the port-side ID
  assign dst_idx = mst_rsp_i.id[`MUX_ID_W +: `MUX_PORT_IDX_W];

  always_comb begin
    dst_onehot = '0;
    if (mst_rsp_valid_i) begin
      dst_onehot[dst_idx] = 1'b1;
    end
  end

  // Prefix removed, code passed as is
  assign port_rsp_o.id   = mst_rsp_i.id[`MUX_ID_W-1:0];
  assign port_rsp_o.resp = mst_rsp_i.resp;

  assign port_rsp_valid_o = dst_onehot;
  assign done_o           = dst_onehot;   // Frees one outstanding slot

endmodule

`default_nettype wire

/* rr_arbiter.sv */
// Round-robin merge of the port slices onto one registered master request
`default_nettype none

`include "mux_settings.svh"

module rr_arbiter (
  input  wire logic                                          periph_clk,
  input  wire logic                                          rst_n_i,
  input  wire logic [`MUX_NUM_PORTS-1:0]                     slv_valid_i,
  input  wire slink_mux_pkg::mst_req_t [`MUX_NUM_PORTS-1:0]  slv_req_i,
  output logic [`MUX_NUM_PORTS-1:0]                          grant_o,
  output logic                                               mst_valid_o,
  output slink_mux_pkg::mst_req_t                            mst_req_o,
  input  wire logic                                          mst_ready_i
);

  logic                     out_valid_q;
  slink_mux_pkg::mst_req_t  out_req_q;
  slink_mux_pkg::port_idx_t last_q;      // Last granted port
  slink_mux_pkg::port_idx_t win_idx;
  logic                     found;
  logic                     can_load;

  // Output register free, or drained by the master this cycle
  assign can_load = ~out_valid_q | mst_ready_i;

  ////////////////////
  // Winner search
  ////////////////////

  // Walk the ports after the last grant, wrapping around to it
  always_comb begin
    slink_mux_pkg::port_idx_t cand;
    found   = 1'b0;
    win_idx = last_q;
    for (int i = 1; i <= `MUX_NUM_PORTS; i++) begin
      cand = last_q + slink_mux_pkg::port_idx_t'(i);
      if (!found && slv_valid_i[cand]) begin
        found   = 1'b1;
        win_idx = cand;
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (can_load && found) begin
      grant_o[win_idx] = 1'b1;
    end
  end

  ////////////////////
  // Master register
  ////////////////////

  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      last_q      <= '1;     // First pick after reset is port 0
    end else if (can_load) begin
      out_valid_q <= found;
      if (found) begin
        last_q <= win_idx;
      end
    end
  end

  always_ff @(posedge periph_clk) begin
    if (can_load && found) begin
      out_req_q <= slv_req_i[win_idx];
    end
  end

  assign mst_valid_o = out_valid_q;
  assign mst_req_o   = out_req_q;

endmodule

`default_nettype wire

/* port_slice.sv */
// Per-port request stage: one-entry request register, ID widening and outstanding counter
`default_nettype none

`include "mux_settings.svh"

module port_slice (
  input  wire logic                     periph_clk,
  input  wire logic                     rst_n_i,
  input  wire slink_mux_pkg::port_idx_t port_idx_i,   // Fixed per instance
  input  wire logic                     req_valid_i,
  input  wire slink_mux_pkg::port_req_t req_i,
  output logic                          req_ready_o,
  output logic                          slv_valid_o,
  output slink_mux_pkg::mst_req_t       slv_req_o,
  input  wire logic                     grant_i,
  input  wire logic                     done_i          // Response seen for this port
);

  localparam logic [`MUX_CNT_W-1:0] CntMax = `MUX_CNT_W'(`MUX_MAX_OUTSTANDING);

  logic                    valid_q;
  slink_mux_pkg::mst_req_t req_q;
  logic [`MUX_CNT_W-1:0]   cnt_q;
  logic                    below_limit;
  logic                    slot_free;
  logic                    accept;

  ////////////////////
  // Handshake
  ////////////////////

  assign below_limit = (cnt_q < CntMax);
  assign slot_free   = ~valid_q | grant_i;   // Empty, or leaving this cycle
  assign req_ready_o = slot_free & below_limit;
  assign accept      = req_valid_i & req_ready_o;

  assign slv_valid_o = valid_q;
  assign slv_req_o   = req_q;

  ////////////////////
  // Request register
  ////////////////////

  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (grant_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, loaded with the widened ID
  always_ff @(posedge periph_clk) begin
    if (accept) begin
      req_q.addr <= req_i.addr;
      req_q.data <= req_i.data;
      req_q.id   <= {port_idx_i, req_i.id};   // Origin port goes in front
    end
  end

  ////////////////////
  // Outstanding count
  ////////////////////

  // Up on accept, down on completion, both at once cancel
  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({accept, done_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* slink_mux_pkg.sv */
// Shared types of the write-request multiplexer: field vectors, request and response structs
`default_nettype none

`include "mux_settings.svh"

package slink_mux_pkg;

  typedef logic [`MUX_ADDR_W-1:0]                 addr_t;
  typedef logic [`MUX_DATA_W-1:0]                 data_t;
  typedef logic [`MUX_ID_W-1:0]                   port_id_t;
  typedef logic [`MUX_PORT_IDX_W+`MUX_ID_W-1:0]   mst_id_t;    // Port index on top
  typedef logic [`MUX_PORT_IDX_W-1:0]             port_idx_t;
  typedef logic [1:0]                             resp_t;

  // Requests, one data word each
  typedef struct packed {
    addr_t    addr;
    data_t    data;
    port_id_t id;
  } port_req_t;

  typedef struct packed {
    addr_t    addr;
    data_t    data;
    mst_id_t  id;
  } mst_req_t;

  // Responses
  typedef struct packed {
    port_id_t id;
    resp_t    resp;
  } port_rsp_t;

  typedef struct packed {
    mst_id_t  id;
    resp_t    resp;
  } mst_rsp_t;

endpackage

`default_nettype wire

/* mux_settings.svh */
// Write-request multiplexer settings: port count, field widths and outstanding limit
`ifndef MUX_SETTINGS_SVH
`define MUX_SETTINGS_SVH

////////////////////
// Port count
////////////////////

`define MUX_NUM_PORTS        4   // External requester ports
`define MUX_PORT_IDX_W       2   // Enough to index every port

////////////////////
// Field widths
////////////////////

`define MUX_ADDR_W           32
`define MUX_DATA_W           32
`define MUX_ID_W             4   // ID as seen on a requester port

// Outstanding transaction tracking, per port
`define MUX_MAX_OUTSTANDING  8
`define MUX_CNT_W            4   // Must hold the limit itself

`endif
